// ==== include/cp0Masks.svh ====
`ifndef CP0_MASKS_SVH
`define CP0_MASKS_SVH

// Writable bits
`define CP0_STATUS_MASK  32'h1040_ff07
`define CP0_CAUSE_MASK   32'h0000_0300
`define CP0_COMPARE_MASK 32'hffff_ffff
`define CP0_EPC_MASK     32'hffff_ffff
`define CP0_EBASE_MASK   32'h3fff_f000

// Reset values
`define CP0_STATUS_RST   32'h1040_0004
`define CP0_CONFIG_RST   32'h8000_0002
`define CP0_EBASE_RST    32'h8000_0000
`define CP0_COMPARE_RST  32'hffff_ffff

`endif

// ==== source/cp0RegPkg.sv ====
`default_nettype none

package cp0RegPkg;

    typedef logic [4:0]  cp0AddrT;
    typedef logic [2:0]  cp0SelT;
    typedef logic [31:0] cp0WordT;

    // Register numbers of the kept registers
    localparam cp0AddrT regBadVAddr = 5'd8;
    localparam cp0AddrT regCount    = 5'd9;
    localparam cp0AddrT regCompare  = 5'd11;
    localparam cp0AddrT regStatus   = 5'd12;
    localparam cp0AddrT regCause    = 5'd13;
    localparam cp0AddrT regEpc      = 5'd14;
    localparam cp0AddrT regPrId     = 5'd15;   // EBase at select 1
    localparam cp0AddrT regConfig   = 5'd16;   // Config1 at select 1

    // Selects
    localparam cp0SelT selMain    = 3'd0;
    localparam cp0SelT selPrId    = 3'd0;
    localparam cp0SelT selEBase   = 3'd1;
    localparam cp0SelT selConfig  = 3'd0;
    localparam cp0SelT selConfig1 = 3'd1;

    // Move-to-CP0 request from the pipeline
    typedef struct packed {
        logic    valid;
        cp0AddrT addr;
        cp0SelT  sel;
        cp0WordT data;
    } cp0WriteT;

endpackage

`default_nettype wire

// ==== source/excPkg.sv ====
`default_nettype none

package excPkg;

    typedef enum logic [2:0] {
        excInt,
        excAdEL,
        excAdES,
        excRI,
        excSys,
        excBp,
        excOv,
        excEret
    } excKindE;

    typedef logic [4:0] excCodeT;

    localparam excCodeT codeInt  = 5'd0;
    localparam excCodeT codeAdEL = 5'd4;
    localparam excCodeT codeAdES = 5'd5;
    localparam excCodeT codeSys  = 5'd8;
    localparam excCodeT codeBp   = 5'd9;
    localparam excCodeT codeRI   = 5'd10;
    localparam excCodeT codeOv   = 5'd12;

    typedef struct packed {
        logic               valid;
        excKindE            kind;
        cp0RegPkg::cp0WordT pc;
        logic               isDs;      // Faulting instruction sits in a delay slot
        cp0RegPkg::cp0WordT badAddr;
    } excEventT;

    // Towards the pipeline
    typedef struct packed {
        logic               exl;
        logic               intPending;
        cp0RegPkg::cp0WordT target;    // Handler or return address
    } excStatusT;

endpackage

`default_nettype wire

// ==== source/cp0Timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cp0Masks.svh"

module cp0Timer #(
    parameter int countDiv = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire cp0RegPkg::cp0WriteT  gatedWr,
    output cp0RegPkg::cp0WordT        count,
    output cp0RegPkg::cp0WordT        compare,
    output logic                      timerInt
);
    import cp0RegPkg::*;

    localparam int divW = (countDiv > 1) ? $clog2(countDiv) : 1;
    localparam cp0WordT compareMask = `CP0_COMPARE_MASK;

    logic [divW-1:0] divCnt;
    logic            step;
    logic            wrCount;
    logic            wrCompare;

    assign step      = (divCnt == divW'(countDiv - 1));
    assign wrCount   = gatedWr.valid && gatedWr.addr == regCount && gatedWr.sel == selMain;
    assign wrCompare = gatedWr.valid && gatedWr.addr == regCompare && gatedWr.sel == selMain;

    always_ff @(posedge clk) begin
        if (rst) begin
            divCnt   <= '0;
            count    <= '0;
            compare  <= `CP0_COMPARE_RST;  // Far from Count so no match out of reset
            timerInt <= 1'b0;
        end else begin
            divCnt <= step ? '0 : divCnt + 1'b1;
            if (wrCount)
                count <= gatedWr.data;
            else if (step)
                count <= count + 32'd1;
            if (wrCompare) begin
                compare  <= (compare & ~compareMask) | (gatedWr.data & compareMask);
                timerInt <= 1'b0;           // Acknowledge
            end else if (count == compare) begin
                timerInt <= 1'b1;
            end
        end
    end

    // Timer interrupt only rises after a real match
    assert property (@(posedge clk) disable iff (rst) $rose(timerInt) |-> $past(count == compare));

endmodule

`default_nettype wire

// ==== source/cp0ExcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cp0Masks.svh"

module cp0ExcUnit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire excPkg::excEventT     exc,
    input  wire cp0RegPkg::cp0WriteT  gatedWr,
    input  wire logic                 bev,
    input  wire cp0RegPkg::cp0WordT   ebase,
    output logic                      exl,
    output cp0RegPkg::cp0WordT        epc,
    output cp0RegPkg::cp0WordT        badVAddr,
    output logic                      bd,
    output excPkg::excCodeT           excCode,
    output cp0RegPkg::cp0WordT        target
);
    import cp0RegPkg::*;
    import excPkg::*;

    localparam cp0WordT statusMask = `CP0_STATUS_MASK;
    localparam cp0WordT epcMask    = `CP0_EPC_MASK;
    localparam cp0WordT bootVector = 32'hbfc0_0380;
    localparam cp0WordT vecOffset  = 32'h0000_0180;

    logic isEret;
    logic enter;
    logic isAddrErr;
    logic wrStatus;
    logic wrEpc;

    function automatic excCodeT kindToCode(input excKindE kind);
        excCodeT code;
        case (kind)
            excAdEL: code = codeAdEL;
            excAdES: code = codeAdES;
            excRI:   code = codeRI;
            excSys:  code = codeSys;
            excBp:   code = codeBp;
            excOv:   code = codeOv;
            default: code = codeInt;
        endcase
        return code;
    endfunction

    assign isEret    = exc.valid && exc.kind == excEret;
    assign enter     = exc.valid && !isEret && !exl;   // Nested events are ignored
    assign isAddrErr = exc.kind == excAdEL || exc.kind == excAdES;
    assign wrStatus  = gatedWr.valid && gatedWr.addr == regStatus && gatedWr.sel == selMain;
    assign wrEpc     = gatedWr.valid && gatedWr.addr == regEpc && gatedWr.sel == selMain;

    always_ff @(posedge clk) begin
        if (rst) begin
            exl     <= 1'b0;
            bd      <= 1'b0;
            excCode <= codeInt;
        end else if (isEret) begin
            exl <= 1'b0;
        end else if (enter) begin
            exl     <= 1'b1;
            bd      <= exc.isDs;
            excCode <= kindToCode(exc.kind);
        end else if (wrStatus && statusMask[1]) begin
            exl <= gatedWr.data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (enter)
            epc <= exc.isDs ? exc.pc - 32'd4 : exc.pc;   // Restart at the branch
        else if (wrEpc)
            epc <= (epc & ~epcMask) | (gatedWr.data & epcMask);
        if (enter && isAddrErr)
            badVAddr <= exc.badAddr;
    end

    always_comb begin
        if (isEret)
            target = epc;
        else if (bev)
            target = bootVector;
        else
            target = ebase + vecOffset;
    end

    // Pipeline must not issue eret outside a handler
    assert property (@(posedge clk) disable iff (rst) isEret |-> exl);

endmodule

`default_nettype wire

// ==== source/cp0RegFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cp0Masks.svh"

module cp0RegFile #(
    parameter cp0RegPkg::cp0WordT prId = 32'h0001_8000
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire cp0RegPkg::cp0WriteT  wr,
    input  wire logic                 excValid,
    input  wire cp0RegPkg::cp0AddrT   rdAddr,
    input  wire cp0RegPkg::cp0SelT    rdSel,
    input  wire logic [5:0]           hwInt,
    input  wire cp0RegPkg::cp0WordT   count,
    input  wire cp0RegPkg::cp0WordT   compare,
    input  wire logic                 timerInt,
    input  wire logic                 exl,
    input  wire cp0RegPkg::cp0WordT   epc,
    input  wire cp0RegPkg::cp0WordT   badVAddr,
    input  wire logic                 bd,
    input  wire excPkg::excCodeT      excCode,
    output cp0RegPkg::cp0WriteT       gatedWr,
    output logic                      bev,
    output cp0RegPkg::cp0WordT        ebase,
    output cp0RegPkg::cp0WordT        rdData,
    output logic                      intPending
);
    import cp0RegPkg::*;

    // EXL lives in the exception unit
    localparam cp0WordT statusMask = `CP0_STATUS_MASK & ~32'h0000_0002;
    localparam cp0WordT causeMask  = `CP0_CAUSE_MASK;
    localparam cp0WordT ebaseMask  = `CP0_EBASE_MASK;
    localparam cp0WordT configVal  = `CP0_CONFIG_RST;
    localparam cp0WordT config1Val = 32'h0000_0000;   // No TLB, no caches, no FPU

    cp0WordT    statusReg;
    cp0WordT    status;
    cp0WordT    cause;
    logic [5:0] ipHw;
    logic [1:0] ipSw;
    logic [7:0] ip;
    logic       wrStatus;
    logic       wrCause;
    logic       wrEBase;

    // An exception in the same cycle wins over the software write
    always_comb begin
        gatedWr       = wr;
        gatedWr.valid = wr.valid && !excValid;
    end

    assign wrStatus = gatedWr.valid && gatedWr.addr == regStatus && gatedWr.sel == selMain;
    assign wrCause  = gatedWr.valid && gatedWr.addr == regCause && gatedWr.sel == selMain;
    assign wrEBase  = gatedWr.valid && gatedWr.addr == regPrId && gatedWr.sel == selEBase;

    always_ff @(posedge clk) begin
        if (rst) begin
            statusReg <= `CP0_STATUS_RST;
            ebase     <= `CP0_EBASE_RST;
            ipHw      <= '0;
            ipSw      <= '0;
        end else begin
            ipHw <= hwInt;
            if (wrStatus)
                statusReg <= (statusReg & ~statusMask) | (gatedWr.data & statusMask);
            if (wrCause)
                ipSw <= gatedWr.data[9:8] & causeMask[9:8];
            if (wrEBase)
                ebase <= (ebase & ~ebaseMask) | (gatedWr.data & ebaseMask);
        end
    end

    assign ip     = {ipHw[5] | timerInt, ipHw[4:0], ipSw};   // Timer shares IP7
    assign status = {statusReg[31:2], exl, statusReg[0]};
    assign cause  = {bd, timerInt, 14'b0, ip, 1'b0, excCode, 2'b00};
    assign bev    = statusReg[22];

    assign intPending = statusReg[0] && !exl && !statusReg[2] && |(ip & statusReg[15:8]);

    always_comb begin
        rdData = '0;
        case (rdAddr)
            regBadVAddr: if (rdSel == selMain) rdData = badVAddr;
            regCount:    if (rdSel == selMain) rdData = count;
            regCompare:  if (rdSel == selMain) rdData = compare;
            regStatus:   if (rdSel == selMain) rdData = status;
            regCause:    if (rdSel == selMain) rdData = cause;
            regEpc:      if (rdSel == selMain) rdData = epc;
            regPrId: begin
                if (rdSel == selPrId)
                    rdData = prId;
                else if (rdSel == selEBase)
                    rdData = ebase;
            end
            regConfig: begin
                if (rdSel == selConfig)
                    rdData = configVal;
                else if (rdSel == selConfig1)
                    rdData = config1Val;
            end
            default: rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cp0Top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0Top #(
    parameter int                 countDiv = 2,
    parameter cp0RegPkg::cp0WordT prId     = 32'h0001_8000
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire cp0RegPkg::cp0WriteT  wr,
    input  wire cp0RegPkg::cp0AddrT   rdAddr,
    input  wire cp0RegPkg::cp0SelT    rdSel,
    input  wire excPkg::excEventT     exc,
    input  wire logic [5:0]           hwInt,
    output cp0RegPkg::cp0WordT        rdData,
    output excPkg::excStatusT         excStat
);
    import cp0RegPkg::*;
    import excPkg::*;

    cp0WriteT gatedWr;
    cp0WordT  count;
    cp0WordT  compare;
    logic     timerInt;
    logic     exl;
    cp0WordT  epc;
    cp0WordT  badVAddr;
    logic     bd;
    excCodeT  excCode;
    logic     bev;
    cp0WordT  ebase;
    logic     intPending;
    cp0WordT  target;

    cp0RegFile #(
        .prId(prId)
    ) i_cp0RegFile (
        .clk, .rst, .wr,
        .excValid(exc.valid),
        .rdAddr, .rdSel, .hwInt,
        .count, .compare, .timerInt,
        .exl, .epc, .badVAddr, .bd, .excCode,
        .gatedWr, .bev, .ebase, .rdData, .intPending
    );

    cp0Timer #(
        .countDiv(countDiv)
    ) i_cp0Timer (
        .clk, .rst, .gatedWr, .count, .compare, .timerInt
    );

    cp0ExcUnit i_cp0ExcUnit (
        .clk, .rst, .exc, .gatedWr, .bev, .ebase,
        .exl, .epc, .badVAddr, .bd, .excCode, .target
    );

    assign excStat = '{exl: exl, intPending: intPending, target: target};

endmodule

`default_nettype wire

// ==== tb/cp0Tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cp0Masks.svh"

module cp0Tb;
    import cp0RegPkg::*;
    import excPkg::*;

    localparam int      countDivVal = 2;
    localparam cp0WordT prIdVal     = 32'h0001_8027;

    typedef enum logic [3:0] {
        opWrite, opRead, opExc, opWrExc, opWait, opHwInt, opPend, opExl, opCount
    } opE;

    typedef struct packed {
        opE      op;
        cp0AddrT addr;
        cp0SelT  sel;
        cp0WordT data;     // Write data, badAddr, wait length or hwInt lines
        excKindE kind;
        cp0WordT pc;
        logic    isDs;
        cp0WordT exp;
    } rowT;

    logic       clk;
    logic       rst;
    cp0WriteT   wr;
    cp0AddrT    rdAddr;
    cp0SelT     rdSel;
    excEventT   exc;
    logic [5:0] hwInt;
    cp0WordT    rdData;
    excStatusT  excStat;

    rowT         rows[$];
    int unsigned waits = 0;
    int unsigned limit = 0;
    int unsigned cycles = 0;
    int unsigned sinceRel = 0;
    logic [31:0] lfsrState;

    // Reference state of the registers while the table is built
    cp0WordT    mStatus;
    cp0WordT    mEbase;
    cp0WordT    mEpc;
    cp0WordT    mBad;
    cp0WordT    mCompare;
    logic       mBd;
    excCodeT    mCode;
    logic [5:0] mHw;
    logic [1:0] mSw;
    logic       mTi;

    cp0Top #(
        .countDiv(countDivVal),
        .prId(prIdVal)
    ) i_cp0Top (
        .clk, .rst, .wr, .rdAddr, .rdSel, .exc, .hwInt, .rdData, .excStat
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst)
            sinceRel <= sinceRel + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: the stimulus table did not finish within %0d cycles", limit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randWord(output cp0WordT w);
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrStep(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    function automatic cp0WordT mergeMasked(input cp0WordT old, input cp0WordT d,
                                            input cp0WordT mask);
        return (old & ~mask) | (d & mask);
    endfunction

    function automatic cp0WordT causeWord();
        logic [7:0] ip;
        ip = {mHw[5] | mTi, mHw[4:0], mSw};
        return {mBd, mTi, 14'b0, ip, 1'b0, mCode, 2'b00};
    endfunction

    function automatic cp0WordT vecTarget();
        return mStatus[22] ? 32'hbfc0_0380 : mEbase + 32'h0000_0180;
    endfunction

    task automatic checkEq(input string name, input cp0WordT got, input cp0WordT exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic pushRow(input opE op, input cp0AddrT a, input cp0SelT s, input cp0WordT d,
                           input excKindE k, input cp0WordT pc, input logic ds,
                           input cp0WordT e);
        rows.push_back('{op, a, s, d, k, pc, ds, e});
        if (op == opWait)
            waits += d;
    endtask

    task automatic queueWrite(input cp0AddrT a, input cp0SelT s, input cp0WordT d);
        pushRow(opWrite, a, s, d, excInt, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic expectRead(input cp0AddrT a, input cp0SelT s, input cp0WordT e);
        pushRow(opRead, a, s, 32'h0, excInt, 32'h0, 1'b0, e);
    endtask

    task automatic expectFlag(input opE op, input cp0WordT e);
        pushRow(op, regBadVAddr, selMain, 32'h0, excInt, 32'h0, 1'b0, e);
    endtask

    task automatic enterModel(input excKindE k, input cp0WordT pc, input logic ds,
                              input cp0WordT bad, input excCodeT code);
        if (k == excEret) begin
            mStatus[1] = 1'b0;
        end else if (!mStatus[1]) begin
            mStatus[1] = 1'b1;
            mBd = ds;
            mEpc = ds ? pc - 32'd4 : pc;   // Restart at the branch
            mCode = code;
            if (k == excAdEL || k == excAdES)
                mBad = bad;
        end
    endtask

    task automatic raiseExc(input excKindE k, input cp0WordT pc, input logic ds,
                            input cp0WordT bad, input excCodeT code);
        cp0WordT e;
        e = (k == excEret) ? mEpc : vecTarget();
        pushRow(opExc, regBadVAddr, selMain, bad, k, pc, ds, e);
        enterModel(k, pc, ds, bad, code);
    endtask

    task automatic writeModel(input cp0AddrT a, input cp0WordT d);
        queueWrite(a, selMain, d);
        case (a)
            regStatus:  mStatus = mergeMasked(mStatus, d, `CP0_STATUS_MASK);
            regEpc:     mEpc = mergeMasked(mEpc, d, `CP0_EPC_MASK);
            regCompare: mCompare = mergeMasked(mCompare, d, `CP0_COMPARE_MASK);
            regCause:   mSw = d[9:8];
            default:    ;
        endcase
    endtask

    task automatic buildTable();
        cp0WordT d;
        mStatus = `CP0_STATUS_RST;
        mEbase = `CP0_EBASE_RST;
        mCompare = `CP0_COMPARE_RST;
        mEpc = '0;
        mBad = '0;
        mBd = 1'b0;
        mCode = '0;
        mHw = '0;
        mSw = '0;
        mTi = 1'b0;

        expectRead(regStatus, selMain, mStatus);
        expectRead(regPrId, selPrId, prIdVal);
        expectRead(regPrId, selEBase, mEbase);
        expectRead(regCause, selMain, causeWord());
        expectRead(regConfig, selConfig, `CP0_CONFIG_RST);
        expectFlag(opPend, 32'h0);
        expectFlag(opExl, 32'h0);
        expectFlag(opCount, 32'h0);

        // Masked writes
        randWord(d);
        writeModel(regStatus, d);
        expectRead(regStatus, selMain, mStatus);
        randWord(d);
        writeModel(regEpc, d);
        expectRead(regEpc, selMain, mEpc);
        randWord(d);
        writeModel(regCompare, d);
        expectRead(regCompare, selMain, mCompare);
        randWord(d);
        queueWrite(regPrId, selEBase, d);
        mEbase = mergeMasked(mEbase, d, `CP0_EBASE_MASK);
        expectRead(regPrId, selEBase, mEbase);

        // Exception entry and return, BEV clear
        writeModel(regStatus, 32'h1000_0000);
        expectRead(regStatus, selMain, mStatus);
        raiseExc(excOv, 32'h8000_1004, 1'b1, 32'h0, codeOv);
        expectRead(regEpc, selMain, mEpc);
        expectRead(regCause, selMain, causeWord());
        expectFlag(opExl, 32'h1);
        raiseExc(excEret, 32'h0, 1'b0, 32'h0, codeInt);
        expectFlag(opExl, 32'h0);
        raiseExc(excAdEL, 32'h8000_2000, 1'b0, 32'h1234_5679, codeAdEL);
        expectRead(regBadVAddr, selMain, mBad);
        expectRead(regEpc, selMain, mEpc);
        raiseExc(excSys, 32'h8000_3000, 1'b0, 32'h0, codeSys);   // Ignored, EXL set
        expectRead(regEpc, selMain, mEpc);
        expectRead(regCause, selMain, causeWord());
        raiseExc(excEret, 32'h0, 1'b0, 32'h0, codeInt);
        expectFlag(opExl, 32'h0);

        // BEV set selects the boot vector
        writeModel(regStatus, 32'h1040_0000);
        raiseExc(excBp, 32'h8000_5000, 1'b0, 32'h0, codeBp);
        expectRead(regCause, selMain, causeWord());
        raiseExc(excEret, 32'h0, 1'b0, 32'h0, codeInt);
        writeModel(regStatus, 32'h1000_0000);

        // Timer
        expectFlag(opCount, 32'h0);
        queueWrite(regCount, selMain, 32'h0000_0100);
        writeModel(regCompare, 32'h0000_0104);
        mTi = 1'b0;
        pushRow(opWait, regBadVAddr, selMain, 32'd16, excInt, 32'h0, 1'b0, 32'h0);
        mTi = 1'b1;
        expectRead(regCause, selMain, causeWord());
        writeModel(regCompare, 32'hffff_0000);
        mTi = 1'b0;
        expectRead(regCause, selMain, causeWord());

        // Hardware interrupt on line 0, IM2
        writeModel(regStatus, 32'h1000_0401);
        expectFlag(opPend, 32'h0);
        pushRow(opHwInt, regBadVAddr, selMain, 32'h1, excInt, 32'h0, 1'b0, 32'h0);
        mHw = 6'b00_0001;
        expectRead(regCause, selMain, causeWord());
        expectFlag(opPend, 32'h1);
        writeModel(regStatus, 32'h1000_0001);
        expectFlag(opPend, 32'h0);
        pushRow(opHwInt, regBadVAddr, selMain, 32'h0, excInt, 32'h0, 1'b0, 32'h0);
        mHw = 6'b00_0000;

        // Software interrupt, then a write that loses to an exception
        writeModel(regStatus, 32'h1000_0101);
        expectFlag(opPend, 32'h0);
        writeModel(regCause, 32'h0000_0100);
        expectFlag(opPend, 32'h1);
        expectRead(regCause, selMain, causeWord());
        pushRow(opWrExc, regCause, selMain, 32'h0, excSys, 32'h8000_4000, 1'b0, vecTarget());
        enterModel(excSys, 32'h8000_4000, 1'b0, 32'h0, codeSys);
        expectRead(regCause, selMain, causeWord());
        expectFlag(opExl, 32'h1);
        expectFlag(opPend, 32'h0);
        raiseExc(excEret, 32'h0, 1'b0, 32'h0, codeInt);
        expectFlag(opExl, 32'h0);
        writeModel(regCause, 32'h0000_0000);
        expectRead(regCause, selMain, causeWord());
    endtask

    task automatic applyRow(input rowT r);
        @(posedge clk);
        wr <= '0;
        exc <= '0;
        case (r.op)
            opWrite: wr <= '{1'b1, r.addr, r.sel, r.data};
            opRead: begin
                rdAddr <= r.addr;
                rdSel <= r.sel;
                @(negedge clk);
                checkEq($sformatf("rdData[%0d.%0d]", r.addr, r.sel), rdData, r.exp);
            end
            opExc: begin
                exc <= '{1'b1, r.kind, r.pc, r.isDs, r.data};
                @(negedge clk);
                checkEq("excStat.target", excStat.target, r.exp);
            end
            opWrExc: begin
                wr <= '{1'b1, r.addr, r.sel, r.data};
                exc <= '{1'b1, r.kind, r.pc, r.isDs, 32'h0};
                @(negedge clk);
                checkEq("excStat.target", excStat.target, r.exp);
            end
            opWait: repeat (r.data) @(posedge clk);
            opHwInt: hwInt <= r.data[5:0];
            opPend: begin
                @(negedge clk);
                checkEq("excStat.intPending", 32'(excStat.intPending), r.exp);
            end
            opExl: begin
                @(negedge clk);
                checkEq("excStat.exl", 32'(excStat.exl), r.exp);
            end
            opCount: begin
                rdAddr <= regCount;
                rdSel <= selMain;
                @(negedge clk);
                checkEq("count", rdData, sinceRel / countDivVal);   // Steps since release
            end
            default: ;
        endcase
    endtask

    initial begin
        rst = 1'b1;
        wr = '0;
        rdAddr = '0;
        rdSel = '0;
        exc = '0;
        hwInt = '0;
        lfsrState = 32'hf7b2;
        buildTable();
        limit = 4 * (rows.size() + waits);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i])
            applyRow(rows[i]);
        @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/cp0RegPkg.sv
source/excPkg.sv
source/cp0Timer.sv
source/cp0ExcUnit.sv
source/cp0RegFile.sv
source/cp0Top.sv
tb/cp0Tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the CP0 testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module cp0Tb -o cp0Sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/cp0Sim > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && { echo "Simulation FAILED"; exit 1; } || echo "Simulation clean"
